// ==== Bender.yml ====
package:
  name: ftoi_unit

sources:
  - include_dirs:
      - source
    files:
      - source/fpu_pkg.sv
      - source/float_unpack.sv
      - source/float_comparator_comb.sv
      - source/rshifter.sv
      - source/rounding_logic.sv
      - source/ftoi_converter.sv
      - source/ftoi_unit.sv
  - target: simulation
    files:
      - bench/ftoi_unit_tb.sv

// ==== bench/ftoi_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ftoi_unit_tb;

	localparam int DIRECTED_COUNT = 30;
	localparam int BURST_COUNT    = 8;
	localparam int RANDOM_COUNT   = 300;
	// each directed operand runs in five modes for both conversions
	localparam int TOTAL_REQUESTS = DIRECTED_COUNT * 10 + 3 + 1 + BURST_COUNT + RANDOM_COUNT;
	localparam int CONV_REQUESTS  = TOTAL_REQUESTS - 3;
	localparam int CYCLE_LIMIT    = 4 * TOTAL_REQUESTS + 200;

	logic                  clk;
	logic                  reset;
	logic                  valid_in;
	logic                  ready_out;
	logic                  valid_out;
	logic                  ready_in;
	fpu_pkg::fpu_op_e      op;
	fpu_pkg::round_mode_e  rm;
	logic [31:0]           operand;
	fpu_pkg::ftoi_result_t result;

	fpu_pkg::ftoi_result_t pending[$];
	fpu_pkg::ftoi_result_t expected;
	integer                seed = 32'h3cce960d;
	int                    cycle_count = 0;
	int                    accepted = 0;

	// zeros, ties, unsigned lower limits, range edges, specials, subnormals
	logic [31:0] directed [DIRECTED_COUNT] = '{
		32'h00000000, 32'h80000000, 32'h3f800000, 32'h3fc00000, 32'h40200000,
		32'hc0200000, 32'hbfc00000, 32'h3f000000, 32'hbf000000, 32'hbeffffff,
		32'hbf7fffff, 32'hbf800000, 32'hbe99999a, 32'h3e99999a, 32'h4effffff,
		32'h4f000000, 32'hcf000000, 32'hcf000001, 32'h4f7fffff, 32'h4f800000,
		32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7f800001, 32'hffc00000,
		32'h00400000, 32'h80400000, 32'h3fbfffff, 32'h4b7fffff, 32'h4b000001
	};

	ftoi_unit UUT (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.op(op),
		.rm(rm),
		.operand(operand),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// expected result from the raw word, using 32.32 fixed point
	function automatic fpu_pkg::ftoi_result_t ftoi_ref(input logic [31:0] value,
			input fpu_pkg::fpu_op_e code, input fpu_pkg::round_mode_e mode);
		fpu_pkg::ftoi_result_t res;
		logic                  sgn;
		logic [7:0]            exp;
		logic [63:0]           fixed;
		logic [63:0]           mag;
		logic                  frac_nonzero;
		logic                  bump;
		logic signed [64:0]    rounded;
		logic signed [64:0]    low;
		logic signed [64:0]    high;
		logic [31:0]           low_sat;
		logic [31:0]           high_sat;
		sgn = value[31];
		exp = value[30:23];
		if (code == fpu_pkg::FPU_OP_CVTFI) begin
			low      = -(65'sd1 <<< 31);
			high     = (65'sd1 <<< 31) - 65'sd1;
			low_sat  = 32'h80000000;
			high_sat = 32'h7fffffff;
		end else begin
			low      = 65'sd0;
			high     = (65'sd1 <<< 32) - 65'sd1;
			low_sat  = 32'h00000000;
			high_sat = 32'hffffffff;
		end
		if (exp == 8'hff) begin
			res.value   = (value[22:0] == 23'd0 && sgn) ? low_sat : high_sat;
			res.invalid = 1'b1;
			res.inexact = 1'b1;
		end else if (exp == 8'd0) begin
			res = '0;
		end else if (exp > 8'd158) begin
			res.value   = sgn ? low_sat : high_sat;
			res.invalid = 1'b1;
			res.inexact = 1'b0;
		end else begin
			// mantissa times 2^(exp - 150), with 32 fraction bits
			if (exp >= 8'd118) begin
				fixed = {40'd0, 1'b1, value[22:0]} << (exp - 8'd118);
			end else begin
				// far below one half, only a sticky remainder is left
				fixed = 64'd1;
			end
			frac_nonzero = fixed[31:0] != 32'd0;
			case (mode)
				fpu_pkg::FPU_RM_RNE: bump = fixed[31] && ((|fixed[30:0]) || fixed[32]);
				fpu_pkg::FPU_RM_RDN: bump = sgn && frac_nonzero;
				fpu_pkg::FPU_RM_RUP: bump = !sgn && frac_nonzero;
				fpu_pkg::FPU_RM_RMM: bump = fixed[31];
				default:             bump = 1'b0;
			endcase
			mag     = {32'd0, fixed[63:32]} + {63'd0, bump};
			rounded = sgn ? -$signed({1'b0, mag}) : $signed({1'b0, mag});
			if (rounded < low) begin
				res.value   = low_sat;
				res.invalid = 1'b1;
				res.inexact = 1'b0;
			end else if (rounded > high) begin
				res.value   = high_sat;
				res.invalid = 1'b1;
				res.inexact = 1'b0;
			end else begin
				res.value   = rounded[31:0];
				res.invalid = 1'b0;
				res.inexact = frac_nonzero;
			end
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] wanted);
		if (actual !== wanted) begin
			$display("[ERROR] time %0t: %s = %h, expected %h", $time, name, actual, wanted);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// called 2 ns after a rising edge, returns 2 ns after the next one
	task automatic send_request(input logic [31:0] value, input fpu_pkg::fpu_op_e code,
			input fpu_pkg::round_mode_e mode);
		valid_in = 1'b1;
		operand  = value;
		op       = code;
		rm       = mode;
		@(posedge clk);
		#2;
		valid_in = 1'b0;
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#2;
	endtask

	// an arithmetic opcode must never be accepted
	task automatic send_rejected(input fpu_pkg::fpu_op_e code);
		valid_in = 1'b1;
		operand  = 32'h3f800000;
		op       = code;
		rm       = fpu_pkg::FPU_RM_RNE;
		@(negedge clk);
		check_value("ready_out", {31'd0, ready_out}, 32'd0);
		wait_cycle();
		valid_in = 1'b0;
	endtask

	// a transfer seen on one falling edge must show its result on the next
	always @(negedge clk) begin
		if (!reset) begin
			if (pending.size() != 0) begin
				expected = pending.pop_front();
				check_value("valid_out", {31'd0, valid_out}, 32'd1);
				check_value("result.value", result.value, expected.value);
				check_value("result.invalid", {31'd0, result.invalid}, {31'd0, expected.invalid});
				check_value("result.inexact", {31'd0, result.inexact}, {31'd0, expected.inexact});
			end else begin
				check_value("valid_out", {31'd0, valid_out}, 32'd0);
				check_value("result.value", result.value, 32'd0);
				check_value("result.invalid", {31'd0, result.invalid}, 32'd0);
				check_value("result.inexact", {31'd0, result.inexact}, 32'd0);
			end
			if (valid_in && ready_out) begin
				pending.push_back(ftoi_ref(operand, op, rm));
				accepted++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: test sequence still running after %0d cycles", cycle_count);
			$display("Checks failed");
			$fatal(1);
		end
	end

	initial begin
		int                   r;
		logic [31:0]          value;
		fpu_pkg::fpu_op_e     code;
		fpu_pkg::round_mode_e mode;
		reset    = 1'b1;
		valid_in = 1'b0;
		ready_in = 1'b1;
		op       = fpu_pkg::FPU_OP_CVTFI;
		rm       = fpu_pkg::FPU_RM_RNE;
		operand  = 32'd0;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		// isolated requests over every mode and both conversions
		for (int i = 0; i < DIRECTED_COUNT; i++) begin
			for (int m = 0; m < 5; m++) begin
				send_request(directed[i], fpu_pkg::FPU_OP_CVTFI, fpu_pkg::round_mode_e'(m));
				wait_cycle();
				send_request(directed[i], fpu_pkg::FPU_OP_CVTFU, fpu_pkg::round_mode_e'(m));
				wait_cycle();
			end
		end

		send_rejected(fpu_pkg::FPU_OP_ADD);
		send_rejected(fpu_pkg::FPU_OP_SUB);
		send_rejected(fpu_pkg::FPU_OP_MUL);

		// consumer stalls while a request waits at the input
		ready_in = 1'b0;
		valid_in = 1'b1;
		operand  = 32'h40200000;
		op       = fpu_pkg::FPU_OP_CVTFI;
		rm       = fpu_pkg::FPU_RM_RNE;
		repeat (3) begin
			@(negedge clk);
			check_value("ready_out", {31'd0, ready_out}, 32'd0);
			wait_cycle();
		end
		ready_in = 1'b1;
		send_request(32'h40200000, fpu_pkg::FPU_OP_CVTFI, fpu_pkg::FPU_RM_RNE);
		for (int k = 0; k < BURST_COUNT; k++) begin
			send_request(directed[k + 2], fpu_pkg::FPU_OP_CVTFI, fpu_pkg::round_mode_e'(k % 5));
		end

		// random sweep, mostly back to back
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			r     = $random(seed);
			code  = r[0] ? fpu_pkg::FPU_OP_CVTFI : fpu_pkg::FPU_OP_CVTFU;
			mode  = fpu_pkg::round_mode_e'({29'd0, r[3:1]} % 5);
			value = $random(seed);
			if (!r[4]) begin
				// keep the exponent near the integer range
				value[30:23] = 8'd110 + 8'({$random(seed)} % 56);
			end
			send_request(value, code, mode);
			if (r[6]) begin
				wait_cycle();
			end
		end

		repeat (3) @(posedge clk);
		if (pending.size() == 0 && accepted == CONV_REQUESTS) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("accepted %0d requests, expected %0d, %0d results missing",
				accepted, CONV_REQUESTS, pending.size());
			$display("Checks failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== ftoi_unit.f ====
+incdir+source
source/fpu_pkg.sv
source/float_unpack.sv
source/float_comparator_comb.sv
source/rshifter.sv
source/rounding_logic.sv
source/ftoi_converter.sv
source/ftoi_unit.sv
bench/ftoi_unit_tb.sv

// ==== source/float_comparator_comb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module float_comparator_comb (
	input  logic [`FPU_WIDTH-1:0] a,
	input  logic [`FPU_WIDTH-1:0] b,
	output logic                  snan_a,
	output logic                  qnan_a,
	output logic                  snan_b,
	output logic                  qnan_b,
	output logic                  greater,
	output logic                  equal,
	output logic                  less,
	output logic                  unordered
);

	localparam int FRAC_WIDTH = `FPU_MAN_WIDTH - 1;

	logic [`FPU_WIDTH-2:0] mag_a;
	logic [`FPU_WIDTH-2:0] mag_b;
	logic                  nan_a;
	logic                  nan_b;
	logic                  both_zero;
	logic                  mag_gt;
	logic                  mag_eq;

	assign mag_a = a[`FPU_WIDTH-2:0];
	assign mag_b = b[`FPU_WIDTH-2:0];

	assign nan_a  = (&a[`FPU_WIDTH-2 -: `FPU_EXP_WIDTH]) && (a[FRAC_WIDTH-1:0] != '0);
	assign nan_b  = (&b[`FPU_WIDTH-2 -: `FPU_EXP_WIDTH]) && (b[FRAC_WIDTH-1:0] != '0);
	assign snan_a = nan_a && !a[FRAC_WIDTH-1];
	assign qnan_a = nan_a && a[FRAC_WIDTH-1];
	assign snan_b = nan_b && !b[FRAC_WIDTH-1];
	assign qnan_b = nan_b && b[FRAC_WIDTH-1];

	assign unordered = nan_a || nan_b;

	// +0 and -0 compare equal
	assign both_zero = (mag_a == '0) && (mag_b == '0);
	assign mag_gt    = mag_a > mag_b;
	assign mag_eq    = mag_a == mag_b;

	always_comb begin
		greater = 1'b0;
		equal   = 1'b0;
		less    = 1'b0;
		if (!unordered) begin
			if (both_zero || (a[`FPU_WIDTH-1] == b[`FPU_WIDTH-1] && mag_eq)) begin
				equal = 1'b1;
			end else if (a[`FPU_WIDTH-1] != b[`FPU_WIDTH-1]) begin
				greater = !a[`FPU_WIDTH-1];
				less    = a[`FPU_WIDTH-1];
			end else begin
				// magnitude order flips for negative values
				greater = mag_gt ^ a[`FPU_WIDTH-1];
				less    = !(mag_gt ^ a[`FPU_WIDTH-1]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/float_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module float_unpack (
	input  logic [`FPU_WIDTH-1:0]  operand,
	output fpu_pkg::float_fields_t fields
);

	localparam int FRAC_WIDTH = `FPU_MAN_WIDTH - 1;

	logic [`FPU_EXP_WIDTH-1:0] exp_field;
	logic [FRAC_WIDTH-1:0]     frac_field;
	logic                      exp_zero;
	logic                      exp_ones;
	logic                      frac_zero;

	assign exp_field  = operand[`FPU_WIDTH-2 -: `FPU_EXP_WIDTH];
	assign frac_field = operand[FRAC_WIDTH-1:0];

	assign exp_zero  = exp_field == '0;
	assign exp_ones  = &exp_field;
	assign frac_zero = frac_field == '0;

	always_comb begin
		fields.sgn = operand[`FPU_WIDTH-1];
		fields.exp = exp_field;
		// hidden bit is one for normal numbers only
		fields.man  = {!exp_zero, frac_field};
		// subnormals are treated as zero
		fields.zero = exp_zero;
		fields.inf  = exp_ones && frac_zero;
		// top fraction bit separates quiet from signalling
		fields.snan = exp_ones && !frac_zero && !frac_field[FRAC_WIDTH-1];
		fields.qnan = exp_ones && frac_field[FRAC_WIDTH-1];
	end

endmodule

`default_nettype wire

// ==== source/fpu_consts.svh ====
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// operand and integer result width
`define FPU_WIDTH 32
`define FPU_EXP_WIDTH 8
// mantissa including the hidden bit
`define FPU_MAN_WIDTH 24

// 31 + bias, exponent that puts the leading one on integer bit 31
`define FPU_FTOI_OFFSET_BASE 8'd158

// integer bits plus one round bit
`define FTOI_SHIFT_WIDTH 33
`define FTOI_SEL_WIDTH 6

// binary32 range limits for signed and unsigned conversion
`define FTOI_SIGNED_MIN 32'hcf000000
`define FTOI_SIGNED_MAX 32'h4effffff
`define FTOI_UNSIGNED_MAX 32'h4f7fffff

// most negative operand that still rounds to zero, per rounding mode
`define FTOI_UMIN_RNE 32'hbf000000
`define FTOI_UMIN_RTZ_RUP 32'hbf7fffff
`define FTOI_UMIN_RMM 32'hbeffffff
`define FTOI_UMIN_RDN 32'h00000000

`endif

// ==== source/fpu_pkg.sv ====
`default_nettype none

`include "fpu_consts.svh"

package fpu_pkg;

	// only the two conversions are accepted by this unit
	typedef enum logic [4:0] {
		FPU_OP_ADD   = 5'd0,
		FPU_OP_SUB   = 5'd1,
		FPU_OP_MUL   = 5'd2,
		FPU_OP_CVTFI = 5'd8,
		FPU_OP_CVTFU = 5'd9
	} fpu_op_e;

	// codes 5 to 7 are reserved
	typedef enum logic [2:0] {
		FPU_RM_RNE = 3'd0,
		FPU_RM_RTZ = 3'd1,
		FPU_RM_RDN = 3'd2,
		FPU_RM_RUP = 3'd3,
		FPU_RM_RMM = 3'd4
	} round_mode_e;

	// one operand after unpacking
	typedef struct packed {
		logic                          sgn;
		logic [`FPU_EXP_WIDTH-1:0]     exp;
		logic [`FPU_MAN_WIDTH-1:0]     man;
		logic                          zero;
		logic                          inf;
		logic                          snan;
		logic                          qnan;
	} float_fields_t;

	typedef struct packed {
		logic [`FPU_WIDTH-1:0] value;
		logic                  invalid;
		logic                  inexact;
	} ftoi_result_t;

endpackage

`default_nettype wire

// ==== source/ftoi_converter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module ftoi_converter (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   valid_in,
	output logic                   ready_out,
	output logic                   valid_out,
	input  logic                   ready_in,
	input  fpu_pkg::fpu_op_e       op,
	input  fpu_pkg::round_mode_e   rm,
	input  fpu_pkg::float_fields_t fields,
	output fpu_pkg::ftoi_result_t  result
);

	// state carried from the shift stage into the rounding stage
	typedef struct packed {
		logic [`FPU_WIDTH-1:0] int_part;
		logic                  round_bit;
		logic                  sticky_bit;
		logic                  sgn;
		fpu_pkg::round_mode_e  rm;
		logic                  negate;
		logic                  skip;
		logic                  invalid;
		logic                  inexact;
	} stage_t;

	stage_t stage_d;
	stage_t stage_q;

	logic                         is_signed;
	logic                         transfer;
	logic [`FPU_WIDTH-1:0]        cmp_operand;
	logic [`FPU_WIDTH-1:0]        cmp_min;
	logic [`FPU_WIDTH-1:0]        cmp_max;
	logic                         below_min;
	logic                         above_max;
	logic                         low_special;
	logic                         high_special;
	logic                         neg_unsigned;
	logic [`FPU_EXP_WIDTH-1:0]    offset;
	logic [`FTOI_SEL_WIDTH-1:0]   shift_sel;
	logic [`FTOI_SHIFT_WIDTH-1:0] shifted;
	logic                         sticky;
	logic [`FPU_WIDTH-1:0]        rounded_mag;
	logic                         round_inexact;

	assign is_signed = op == fpu_pkg::FPU_OP_CVTFI;
	assign ready_out = ready_in && (is_signed || op == fpu_pkg::FPU_OP_CVTFU);
	assign transfer  = valid_in && ready_out;

	// subnormal fraction is dropped so the limits see a plain zero
	assign cmp_operand = {fields.sgn, fields.exp,
		fields.zero ? {(`FPU_MAN_WIDTH-1){1'b0}} : fields.man[`FPU_MAN_WIDTH-2:0]};

	assign low_special  = fields.inf && fields.sgn;
	assign high_special = (fields.inf && !fields.sgn) || fields.snan || fields.qnan;
	assign neg_unsigned = !is_signed && fields.sgn;

	always_comb begin
		if (is_signed) begin
			cmp_min = `FTOI_SIGNED_MIN;
			cmp_max = `FTOI_SIGNED_MAX;
		end else begin
			// small negative values may still round to zero
			case (rm)
				fpu_pkg::FPU_RM_RNE: cmp_min = `FTOI_UMIN_RNE;
				fpu_pkg::FPU_RM_RTZ,
				fpu_pkg::FPU_RM_RUP: cmp_min = `FTOI_UMIN_RTZ_RUP;
				fpu_pkg::FPU_RM_RMM: cmp_min = `FTOI_UMIN_RMM;
				default:             cmp_min = `FTOI_UMIN_RDN;
			endcase
			cmp_max = `FTOI_UNSIGNED_MAX;
		end
	end

	float_comparator_comb lower_cmp (
		.a(cmp_operand), .b(cmp_min),
		.snan_a(), .qnan_a(), .snan_b(), .qnan_b(),
		.greater(), .equal(), .less(below_min), .unordered()
	);

	float_comparator_comb upper_cmp (
		.a(cmp_operand), .b(cmp_max),
		.snan_a(), .qnan_a(), .snan_b(), .qnan_b(),
		.greater(above_max), .equal(), .less(), .unordered()
	);

	// shift = 31 + bias - biased exponent, clamped to the select range
	assign offset    = `FPU_FTOI_OFFSET_BASE - fields.exp;
	assign shift_sel = |offset[`FPU_EXP_WIDTH-1:`FTOI_SEL_WIDTH] ? '1
		: offset[`FTOI_SEL_WIDTH-1:0];

	rshifter #(.WIDTH(`FTOI_SHIFT_WIDTH), .SEL_WIDTH(`FTOI_SEL_WIDTH)) align_shift (
		.in({fields.man, {(`FTOI_SHIFT_WIDTH-`FPU_MAN_WIDTH){1'b0}}}),
		.sel(shift_sel),
		.sgn(1'b0),
		.out(shifted),
		.sticky_bit(sticky)
	);

	always_comb begin
		stage_d.int_part   = shifted[`FTOI_SHIFT_WIDTH-1:1];
		stage_d.round_bit  = shifted[0];
		stage_d.sticky_bit = sticky;
		stage_d.sgn        = fields.sgn;
		stage_d.rm         = rm;
		stage_d.negate     = is_signed && fields.sgn;
		stage_d.skip       = 1'b0;
		stage_d.invalid    = 1'b0;
		stage_d.inexact    = 1'b0;
		if (below_min || low_special) begin
			stage_d.int_part = is_signed ? 32'h80000000 : 32'h00000000;
			stage_d.skip     = 1'b1;
			stage_d.invalid  = 1'b1;
			stage_d.inexact  = low_special;
		end else if (above_max || high_special) begin
			stage_d.int_part = is_signed ? 32'h7fffffff : 32'hffffffff;
			stage_d.skip     = 1'b1;
			stage_d.invalid  = 1'b1;
			stage_d.inexact  = high_special;
		end else if (fields.zero || neg_unsigned) begin
			// exact zero is clean, a negative fraction to unsigned is not
			stage_d.int_part = '0;
			stage_d.skip     = 1'b1;
			stage_d.inexact  = !fields.zero;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
			stage_q   <= '0;
		end else if (transfer) begin
			valid_out <= 1'b1;
			stage_q   <= stage_d;
		end else begin
			valid_out <= 1'b0;
			stage_q   <= '0;
		end
	end

	rounding_logic #(.WIDTH(`FPU_WIDTH)) int_round (
		.rm(stage_q.rm),
		.sticky_bit(stage_q.sticky_bit),
		.round_bit(stage_q.round_bit),
		.sgn(stage_q.sgn),
		.in(stage_q.int_part),
		.out(rounded_mag),
		.carry(),
		.inexact(round_inexact)
	);

	always_comb begin
		if (stage_q.skip) begin
			result.value   = stage_q.int_part;
			result.inexact = stage_q.inexact;
		end else begin
			result.value   = stage_q.negate ? -rounded_mag : rounded_mag;
			result.inexact = round_inexact;
		end
		result.invalid = stage_q.invalid;
	end

endmodule

`default_nettype wire

// ==== source/ftoi_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module ftoi_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	output logic                  ready_out,
	output logic                  valid_out,
	input  logic                  ready_in,
	input  fpu_pkg::fpu_op_e      op,
	input  fpu_pkg::round_mode_e  rm,
	input  logic [`FPU_WIDTH-1:0] operand,
	output fpu_pkg::ftoi_result_t result
);

	fpu_pkg::float_fields_t fields;

	float_unpack unpack (
		.operand(operand),
		.fields(fields)
	);

	ftoi_converter converter (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.op(op),
		.rm(rm),
		.fields(fields),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== source/rounding_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module rounding_logic #(
	parameter int WIDTH = 32
) (
	input  fpu_pkg::round_mode_e rm,
	input  logic                 sticky_bit,
	input  logic                 round_bit,
	input  logic                 sgn,
	input  logic [WIDTH-1:0]     in,
	output logic [WIDTH-1:0]     out,
	output logic                 carry,
	output logic                 inexact
);

	logic discarded;
	logic round_up;

	assign discarded = round_bit || sticky_bit;
	assign inexact   = discarded;

	// decide whether the magnitude moves up by one
	always_comb begin
		case (rm)
			fpu_pkg::FPU_RM_RNE: round_up = round_bit && (sticky_bit || in[0]);
			fpu_pkg::FPU_RM_RMM: round_up = round_bit;
			fpu_pkg::FPU_RM_RUP: round_up = !sgn && discarded;
			fpu_pkg::FPU_RM_RDN: round_up = sgn && discarded;
			// RTZ and reserved codes truncate
			default:             round_up = 1'b0;
		endcase
	end

	assign {carry, out} = {1'b0, in} + {{WIDTH{1'b0}}, round_up};

endmodule

`default_nettype wire

// ==== source/rshifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rshifter #(
	parameter int WIDTH     = 33,
	parameter int SEL_WIDTH = 6
) (
	input  logic [WIDTH-1:0]     in,
	input  logic [SEL_WIDTH-1:0] sel,
	input  logic                 sgn,
	output logic [WIDTH-1:0]     out,
	output logic                 sticky_bit
);

	logic signed [WIDTH:0] extended;
	logic signed [WIDTH:0] shifted;

	// the extra top bit carries the fill value
	assign extended = {sgn, in};
	assign shifted  = extended >>> sel;
	assign out      = shifted[WIDTH-1:0];

	// every input bit below the shift amount is lost
	always_comb begin
		sticky_bit = 1'b0;
		for (int i = 0; i < WIDTH; i++) begin
			if (i < sel) begin
				sticky_bit = sticky_bit | in[i];
			end
		end
	end

endmodule

`default_nettype wire
